//--- sources.f
+incdir+.
pyr_pkg.sv
uart_rx.sv
uart_tx.sv
pixel_ram.sv
image_loader.sv
octave_reducer.sv
image_sender.sv
pyr_top.sv
tb_pyr_top.sv

//--- tb_pyr_top.sv
`timescale 1ns/10ps
`include "pyr_cfg.svh"

module tb_pyr_top import pyr_pkg::*; ();
    localparam int BIT_CLKS = `PYR_CLKS_PER_BAUD;
    localparam int IMG_W    = 2 ** `PYR_IMG_W_LOG2;
    localparam int IMG_H    = 2 ** `PYR_IMG_H_LOG2;
    localparam int N_BASE   = IMG_W * IMG_H;
    localparam int N_HALF   = N_BASE / 4;

    logic      clk_100mhz;
    logic      sys_rst;
    logic      uart_rxd_i;
    logic      btn_send_i;
    logic      uart_txd_o;
    logic      image_loaded_o;
    logic      pyramid_done_o;
    logic      sending_o;
    tx_level_t tx_level_o;

    logic [7:0]  base_img [N_BASE]; // reference image, raster order
    logic [7:0]  half_img [N_HALF];
    logic [31:0] lcg_state;

    pyr_top UUT (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .uart_rxd_i     (uart_rxd_i),
        .btn_send_i     (btn_send_i),
        .uart_txd_o     (uart_txd_o),
        .image_loaded_o (image_loaded_o),
        .pyramid_done_o (pyramid_done_o),
        .sending_o      (sending_o),
        .tx_level_o     (tx_level_o)
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("error at time %0t: %s expected 0x%0h, actual 0x%0h",
                                      $time, name, expected, actual));
        end
    endtask

    // every drive and sample lands 1 ns after a rising edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk_100mhz);
            #1;
        end
    endtask

    task automatic build_reference();
        int sum;
        lcg_state = 32'h091b_a80d;
        for (int i = 0; i < N_BASE; i++) begin
            lcg_state   = lcg_next(lcg_state);
            base_img[i] = lcg_state[23:16]; // upper bits are the better random ones
        end
        for (int r = 0; r < IMG_H / 2; r++) begin
            for (int c = 0; c < IMG_W / 2; c++) begin
                sum = base_img[2*r*IMG_W + 2*c] + base_img[2*r*IMG_W + 2*c + 1]
                    + base_img[(2*r+1)*IMG_W + 2*c] + base_img[(2*r+1)*IMG_W + 2*c + 1];
                half_img[r*IMG_W/2 + c] = sum / 4; // floor of the 2x2 mean
            end
        end
    endtask

    task automatic uart_send_byte(input logic [7:0] b);
        uart_rxd_i = 1'b0; // start bit
        step(BIT_CLKS);
        for (int i = 0; i < 8; i++) begin
            uart_rxd_i = b[i];
            step(BIT_CLKS);
        end
        uart_rxd_i = 1'b1;
        step(BIT_CLKS);
    endtask

    // returns at mid stop bit
    task automatic uart_get_byte(output logic [7:0] b);
        int t;
        for (t = 0; t < 2000 && uart_txd_o; t++) step(1);
        if (uart_txd_o) stop_on_failure("timeout while waiting for a start bit on uart_txd_o");
        step(BIT_CLKS / 2);
        check_value("uart_txd_o start bit", 0, uart_txd_o);
        for (int i = 0; i < 8; i++) begin
            step(BIT_CLKS);
            b[i] = uart_txd_o;
        end
        step(BIT_CLKS);
        check_value("uart_txd_o stop bit", 1, uart_txd_o);
    endtask

    task automatic press_button();
        btn_send_i = 1'b1;
        step(4);
        btn_send_i = 1'b0;
    endtask

    task automatic wait_send_done();
        int t;
        for (t = 0; t < 200 && sending_o; t++) step(1);
        if (sending_o) stop_on_failure("sending_o did not fall after the last byte");
    endtask

    task automatic receive_level(input bit half, input int count);
        logic [7:0] b;
        for (int i = 0; i < count; i++) begin
            uart_get_byte(b);
            if (half) check_value($sformatf("half pixel %0d", i), half_img[i], b);
            else      check_value($sformatf("base pixel %0d", i), base_img[i], b);
            check_value("sending_o", 1, sending_o); // high through the last stop bit
        end
    endtask

    task automatic check_after_reset();
        check_value("uart_txd_o", 1, uart_txd_o);
        check_value("image_loaded_o", 0, image_loaded_o);
        check_value("pyramid_done_o", 0, pyramid_done_o);
        check_value("sending_o", 0, sending_o);
        check_value("tx_level_o", LVL_IDLE, tx_level_o);
    endtask

    task automatic check_early_button();
        press_button();
        for (int i = 0; i < 2000; i++) begin
            check_value("tx_level_o", LVL_IDLE, tx_level_o);
            check_value("uart_txd_o", 1, uart_txd_o);
            step(1);
        end
    endtask

    task automatic load_image();
        int t;
        for (int i = 0; i < N_BASE; i++) begin
            uart_send_byte(base_img[i]);
            if (i == N_BASE - 2) check_value("image_loaded_o", 0, image_loaded_o);
        end
        for (t = 0; t < 100 && !image_loaded_o; t++) step(1);
        if (!image_loaded_o) stop_on_failure("image_loaded_o did not rise after the last byte");
        for (t = 0; t < 100 && !pyramid_done_o; t++) step(1);
        if (!pyramid_done_o) stop_on_failure("pyramid_done_o did not rise after loading");
    endtask

    task automatic check_base_level();
        logic [7:0] b;
        press_button();
        check_value("tx_level_o", LVL_BASE, tx_level_o);
        receive_level(1'b0, 20);
        press_button(); // mid transfer, must not restart
        check_value("tx_level_o", LVL_BASE, tx_level_o);
        for (int i = 20; i < N_BASE; i++) begin
            uart_get_byte(b);
            check_value($sformatf("base pixel %0d", i), base_img[i], b);
            check_value("sending_o", 1, sending_o);
        end
        wait_send_done();
    endtask

    task automatic check_half_level();
        press_button();
        check_value("tx_level_o", LVL_HALF, tx_level_o);
        receive_level(1'b1, N_HALF);
        wait_send_done();
    endtask

    task automatic check_wrap_around();
        press_button();
        check_value("tx_level_o", LVL_IDLE, tx_level_o);
        for (int i = 0; i < 200; i++) begin
            check_value("uart_txd_o", 1, uart_txd_o);
            check_value("sending_o", 0, sending_o);
            step(1);
        end
        press_button();
        check_value("tx_level_o", LVL_BASE, tx_level_o);
        receive_level(1'b0, 16);
    endtask

    initial begin
        sys_rst    = 1'b1;
        uart_rxd_i = 1'b1;
        btn_send_i = 1'b0;
        build_reference();
        repeat (8) @(posedge clk_100mhz);
        #1;
        sys_rst = 1'b0;
        check_after_reset();
        check_early_button();
        load_image();
        check_base_level();
        check_half_level();
        check_wrap_around();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- pyr_top.sv
`timescale 1ns/10ps

module pyr_top import pyr_pkg::*; (
    input  logic      clk_100mhz,
    input  logic      sys_rst,
    input  logic      uart_rxd_i,
    input  logic      btn_send_i,
    output logic      uart_txd_o,
    output logic      image_loaded_o,
    output logic      pyramid_done_o,
    output logic      sending_o,
    output tx_level_t tx_level_o
);
    pixel_t     rx_byte;
    logic       rx_byte_valid;
    base_wr_t   base_wr;
    half_wr_t   half_wr;
    base_addr_t base_rd_addr;
    half_addr_t half_rd_addr;
    pixel_t     base_rd_data;
    pixel_t     half_rd_data;

    uart_rx u_rx (
        .clk_100mhz   (clk_100mhz),
        .sys_rst      (sys_rst),
        .rxd_i        (uart_rxd_i),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_byte_valid)
    );

    image_loader u_loader (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .byte_i         (rx_byte),
        .byte_valid_i   (rx_byte_valid),
        .base_wr_o      (base_wr),
        .image_loaded_o (image_loaded_o)
    );

    // watches the same write stream as the base ram
    octave_reducer u_reducer (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .base_wr_i      (base_wr),
        .half_wr_o      (half_wr),
        .pyramid_done_o (pyramid_done_o)
    );

    pixel_ram #(.ADDR_BITS($bits(base_addr_t))) u_base_ram (
        .clk_100mhz (clk_100mhz),
        .wr_i       (base_wr),
        .rd_addr_i  (base_rd_addr),
        .rd_data_o  (base_rd_data)
    );

    pixel_ram #(.ADDR_BITS($bits(half_addr_t))) u_half_ram (
        .clk_100mhz (clk_100mhz),
        .wr_i       (half_wr),
        .rd_addr_i  (half_rd_addr),
        .rd_data_o  (half_rd_data)
    );

    image_sender u_sender (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .btn_send_i     (btn_send_i),
        .pyramid_done_i (pyramid_done_o),
        .base_data_i    (base_rd_data),
        .half_data_i    (half_rd_data),
        .base_rd_addr_o (base_rd_addr),
        .half_rd_addr_o (half_rd_addr),
        .txd_o          (uart_txd_o),
        .sending_o      (sending_o),
        .tx_level_o     (tx_level_o)
    );

endmodule

//--- image_sender.sv
`timescale 1ns/10ps

module image_sender import pyr_pkg::*; (
    input  logic       clk_100mhz,
    input  logic       sys_rst,
    input  logic       btn_send_i,
    input  logic       pyramid_done_i,
    input  pixel_t     base_data_i,
    input  pixel_t     half_data_i,
    output base_addr_t base_rd_addr_o,
    output half_addr_t half_rd_addr_o,
    output logic       txd_o,
    output logic       sending_o,
    output tx_level_t  tx_level_o
);
    localparam base_addr_t BASE_LAST = '1;
    localparam base_addr_t HALF_LAST = base_addr_t'(2 ** $bits(half_addr_t) - 1);

    typedef enum logic [1:0] {
        XF_IDLE,
        XF_FETCH, // address presented to the ram
        XF_LOAD,  // read data valid, uart started
        XF_WAIT   // frame on the line
    } xfer_state_t;

    tx_level_t   level_q;
    tx_level_t   level_d;
    xfer_state_t xfer_q;
    base_addr_t  rd_addr_q;
    base_addr_t  last_addr;
    logic        btn_q;
    logic        btn_edge;
    logic        xfer_go;
    logic        tx_start;
    logic        tx_busy;
    pixel_t      tx_byte;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            btn_q <= 1'b0;
        end else begin
            btn_q <= btn_send_i;
        end
    end

    assign btn_edge = btn_send_i && !btn_q;

    // level steps only once the current transfer is over
    always_comb begin
        level_d = level_q;
        case (level_q)
            LVL_IDLE: if (btn_edge && pyramid_done_i) level_d = LVL_BASE;
            LVL_BASE: if (btn_edge && xfer_q == XF_IDLE) level_d = LVL_HALF;
            LVL_HALF: if (btn_edge && xfer_q == XF_IDLE) level_d = LVL_IDLE;
            default:  level_d = LVL_IDLE;
        endcase
    end

    assign xfer_go = (level_d != level_q) && (level_d != LVL_IDLE);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            level_q <= LVL_IDLE;
        end else begin
            level_q <= level_d;
        end
    end

    assign last_addr = (level_q == LVL_HALF) ? HALF_LAST : BASE_LAST;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            xfer_q    <= XF_IDLE;
            rd_addr_q <= '0;
        end else begin
            case (xfer_q)
                XF_IDLE: if (xfer_go) begin
                    rd_addr_q <= '0;
                    xfer_q    <= XF_FETCH;
                end
                XF_FETCH: xfer_q <= XF_LOAD;
                XF_LOAD:  xfer_q <= XF_WAIT; // busy is up next cycle
                XF_WAIT: if (!tx_busy) begin
                    if (rd_addr_q == last_addr) begin
                        xfer_q <= XF_IDLE;
                    end else begin
                        rd_addr_q <= rd_addr_q + 1'b1;
                        xfer_q    <= XF_FETCH;
                    end
                end
                default: xfer_q <= XF_IDLE;
            endcase
        end
    end

    assign tx_start = (xfer_q == XF_LOAD);
    assign tx_byte  = (level_q == LVL_HALF) ? half_data_i : base_data_i;

    uart_tx u_tx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .start_i    (tx_start),
        .byte_i     (tx_byte),
        .txd_o      (txd_o),
        .busy_o     (tx_busy)
    );

    assign base_rd_addr_o = rd_addr_q;
    assign half_rd_addr_o = rd_addr_q[$bits(half_addr_t)-1:0];
    assign sending_o      = (xfer_q != XF_IDLE);
    assign tx_level_o     = level_q;

endmodule

//--- octave_reducer.sv
`timescale 1ns/10ps
`include "pyr_cfg.svh"

module octave_reducer import pyr_pkg::*; (
    input  logic     clk_100mhz,
    input  logic     sys_rst,
    input  base_wr_t base_wr_i,
    output half_wr_t half_wr_o,
    output logic     pyramid_done_o
);
    localparam int W_LOG2 = `PYR_IMG_W_LOG2;

    typedef logic [$bits(pixel_t)+1:0] psum_t; // room for four pixels

    logic [W_LOG2-1:0]                    col;
    logic [$bits(base_addr_t)-W_LOG2-1:0] row;
    logic [W_LOG2-2:0]                    hcol; // column in the half level
    psum_t                                row_sum_q [2**(W_LOG2-1)];
    pixel_t                               left_q;
    psum_t                                pair_sum;
    psum_t                                blk_sum;
    logic                                 blk_done;
    logic                                 half_we_q;
    half_addr_t                           half_addr_q;
    pixel_t                               half_data_q;

    assign {row, col} = base_wr_i.addr;
    assign hcol       = col[W_LOG2-1:1];

    assign pair_sum = psum_t'(left_q) + psum_t'(base_wr_i.data);
    assign blk_sum  = row_sum_q[hcol] + pair_sum;
    assign blk_done = base_wr_i.we && row[0] && col[0]; // bottom right of a 2x2 block

    always_ff @(posedge clk_100mhz) begin
        if (base_wr_i.we) begin
            if (!col[0]) begin
                left_q <= base_wr_i.data;
            end else if (!row[0]) begin
                row_sum_q[hcol] <= pair_sum; // top pair, kept for the odd row
            end
        end
        if (blk_done) begin
            half_addr_q <= {row[$bits(row)-1:1], hcol};
            half_data_q <= blk_sum[$bits(psum_t)-1:2]; // floor of the mean
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            half_we_q      <= 1'b0;
            pyramid_done_o <= 1'b0;
        end else begin
            half_we_q <= blk_done;
            if (half_we_q && half_addr_q == '1) begin
                pyramid_done_o <= 1'b1;
            end
        end
    end

    assign half_wr_o = '{we: half_we_q, addr: half_addr_q, data: half_data_q};

endmodule

//--- image_loader.sv
`timescale 1ns/10ps

module image_loader import pyr_pkg::*; (
    input  logic     clk_100mhz,
    input  logic     sys_rst,
    input  pixel_t   byte_i,
    input  logic     byte_valid_i,
    output base_wr_t base_wr_o,
    output logic     image_loaded_o
);
    base_addr_t pix_addr_q; // next raster position
    logic       wr_we_q;
    base_addr_t wr_addr_q;
    pixel_t     wr_data_q;
    logic       take;

    assign take = byte_valid_i && !image_loaded_o; // extra bytes ignored

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            pix_addr_q     <= '0;
            wr_we_q        <= 1'b0;
            image_loaded_o <= 1'b0;
        end else begin
            wr_we_q <= take;
            if (take) begin
                pix_addr_q <= pix_addr_q + 1'b1;
                if (pix_addr_q == '1) image_loaded_o <= 1'b1; // last pixel
            end
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (take) begin
            wr_addr_q <= pix_addr_q;
            wr_data_q <= byte_i;
        end
    end

    assign base_wr_o = '{we: wr_we_q, addr: wr_addr_q, data: wr_data_q};

    a_no_write_after_load: assert property (
        @(posedge clk_100mhz) disable iff (sys_rst) image_loaded_o |=> !base_wr_o.we
    ) else $error("base write after image loaded");

endmodule

//--- pixel_ram.sv
`timescale 1ns/10ps

module pixel_ram import pyr_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  logic                            clk_100mhz,
    input  logic [ADDR_BITS+$bits(pixel_t):0] wr_i, // base_wr_t or half_wr_t
    input  logic [ADDR_BITS-1:0]            rd_addr_i,
    output pixel_t                          rd_data_o
);
    // same layout as the write structs in pyr_pkg
    typedef struct packed {
        logic                 we;
        logic [ADDR_BITS-1:0] addr;
        pixel_t               data;
    } ram_wr_t;

    ram_wr_t wr;
    pixel_t  mem [2**ADDR_BITS];

    assign wr = ram_wr_t'(wr_i);

    // read first on an address collision
    always_ff @(posedge clk_100mhz) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- uart_tx.sv
`timescale 1ns/10ps
`include "pyr_cfg.svh"

module uart_tx import pyr_pkg::*; (
    input  logic   clk_100mhz,
    input  logic   sys_rst,
    input  logic   start_i,
    input  pixel_t byte_i,
    output logic   txd_o,
    output logic   busy_o
);
    localparam int CLKS = `PYR_CLKS_PER_BAUD;

    logic [$clog2(CLKS)-1:0] baud_cnt_q;
    logic [3:0]              bit_cnt_q; // frame slot, 0 is the start bit
    logic [$bits(pixel_t):0] shift_q;   // data bits then stop bit

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            txd_o      <= 1'b1;
            busy_o     <= 1'b0;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else if (!busy_o) begin
            if (start_i) begin
                busy_o     <= 1'b1;
                txd_o      <= 1'b0; // start bit
                baud_cnt_q <= '0;
                bit_cnt_q  <= '0;
            end
        end else if (baud_cnt_q == CLKS - 1) begin
            baud_cnt_q <= '0;
            if (bit_cnt_q == 4'd9) begin
                busy_o <= 1'b0; // stop bit done
            end else begin
                txd_o     <= shift_q[0];
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (!busy_o && start_i) begin
            shift_q <= {1'b1, byte_i};
        end else if (busy_o && baud_cnt_q == CLKS - 1) begin
            shift_q <= {1'b1, shift_q[$bits(pixel_t):1]};
        end
    end

    // the sender must wait out each frame
    a_no_start_when_busy: assert property (
        @(posedge clk_100mhz) disable iff (sys_rst) busy_o |-> !start_i
    ) else $error("uart_tx started while busy");

endmodule

//--- uart_rx.sv
`timescale 1ns/10ps
`include "pyr_cfg.svh"

module uart_rx import pyr_pkg::*; (
    input  logic   clk_100mhz,
    input  logic   sys_rst,
    input  logic   rxd_i,
    output pixel_t byte_o,
    output logic   byte_valid_o
);
    localparam int CLKS = `PYR_CLKS_PER_BAUD;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t               state_q;
    logic [$clog2(CLKS)-1:0] baud_cnt_q;
    logic [2:0]              bit_cnt_q;
    logic [1:0]              rxd_sync_q; // two-flop synchronizer
    logic                    rxd;

    assign rxd = rxd_sync_q[1];

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            rxd_sync_q <= 2'b11; // line idles high
        end else begin
            rxd_sync_q <= {rxd_sync_q[0], rxd_i};
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state_q      <= RX_IDLE;
            baud_cnt_q   <= '0;
            bit_cnt_q    <= '0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;
            baud_cnt_q   <= baud_cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    baud_cnt_q <= '0;
                    if (!rxd) state_q <= RX_START; // falling edge of start bit
                end
                RX_START: if (baud_cnt_q == CLKS/2 - 1) begin
                    baud_cnt_q <= '0;
                    bit_cnt_q  <= '0;
                    state_q    <= rxd ? RX_IDLE : RX_DATA; // glitch if high at half bit
                end
                RX_DATA: if (baud_cnt_q == CLKS - 1) begin
                    baud_cnt_q <= '0;
                    bit_cnt_q  <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == 3'd7) state_q <= RX_STOP;
                end
                RX_STOP: if (baud_cnt_q == CLKS - 1) begin
                    byte_valid_o <= rxd; // drop byte on framing error
                    state_q      <= RX_IDLE;
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // lsb first, sampled mid bit
    always_ff @(posedge clk_100mhz) begin
        if (state_q == RX_DATA && baud_cnt_q == CLKS - 1) begin
            byte_o <= {rxd, byte_o[$bits(pixel_t)-1:1]};
        end
    end

endmodule

//--- pyr_pkg.sv
`include "pyr_cfg.svh"

package pyr_pkg;

    typedef logic [`PYR_PIX_BITS-1:0] pixel_t;

    // raster addresses {row, col}
    typedef logic [`PYR_IMG_W_LOG2+`PYR_IMG_H_LOG2-1:0] base_addr_t;
    typedef logic [`PYR_IMG_W_LOG2+`PYR_IMG_H_LOG2-3:0] half_addr_t; // half width and height

    typedef struct packed {
        logic       we;
        base_addr_t addr;
        pixel_t     data;
    } base_wr_t;

    typedef struct packed {
        logic       we;
        half_addr_t addr;
        pixel_t     data;
    } half_wr_t;

    // level currently selected for transmit
    typedef enum logic [1:0] {
        LVL_IDLE,
        LVL_BASE,
        LVL_HALF
    } tx_level_t;

endpackage

//--- pyr_cfg.svh
`ifndef PYR_CFG_SVH
`define PYR_CFG_SVH

// image size as log2 of each side
`define PYR_IMG_W_LOG2 4
`define PYR_IMG_H_LOG2 4

// greyscale depth in bits
`define PYR_PIX_BITS 8

// clock cycles per uart bit, 2 Mbaud at 100 MHz
`define PYR_CLKS_PER_BAUD 50

`endif
